//--- filelist.f
+incdir+src
+incdir+verif
src/ex_pkg.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_div.sv
src/ex_lsu.sv
src/ex_stage.sv
verif/ex_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the execution stage testbench with Verilator
set -u

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module ex_stage_tb \
  -Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/ex_stage_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0

//--- src/ex_alu.sv
// Integer ALU
// Single-cycle arithmetic, logic, shift and compare operations,
// result and bubble registered when the stage accepts

`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_alu
  import ex_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic                ex_stall,
  input  logic                id_bubble,
  input  ex_op_e              id_op,
  input  logic [`EX_XLEN-1:0] opA,
  input  logic [`EX_XLEN-1:0] opB,
  output logic [`EX_XLEN-1:0] alu_r,
  output logic                alu_bubble
);

  // Shift amount taken from the low bits of opB
  localparam int SH_W = $clog2(`EX_XLEN);

  logic [SH_W-1:0]     shamt;
  logic [`EX_XLEN-1:0] alu_nxt;
  logic                is_alu;

  assign shamt  = opB[SH_W-1:0];
  assign is_alu = id_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};

  // Operation select
  always_comb begin
    case (id_op)
      OP_ADD:  alu_nxt = opA + opB;
      OP_SUB:  alu_nxt = opA - opB;
      OP_AND:  alu_nxt = opA & opB;
      OP_OR:   alu_nxt = opA | opB;
      OP_XOR:  alu_nxt = opA ^ opB;
      OP_SLL:  alu_nxt = opA << shamt;
      OP_SRL:  alu_nxt = opA >> shamt;
      OP_SRA:  alu_nxt = $signed(opA) >>> shamt;
      // Compares give 0 or 1
      OP_SLT:  alu_nxt = `EX_XLEN'($signed(opA) < $signed(opB));
      OP_SLTU: alu_nxt = `EX_XLEN'(opA < opB);
      default: alu_nxt = '0;
    endcase
  end

  // Bubble low only for an accepted ALU op
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      alu_bubble <= 1'b1;
    end else if (!ex_stall) begin
      alu_bubble <= !(is_alu && !id_bubble);
    end
  end

  // Result
  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      alu_r <= alu_nxt;
    end
  end

endmodule

//--- src/ex_branch.sv
// Branch unit
// Resolves conditional branches and JAL against the predicted direction,
// registers the flush, the corrected next pc and the link address

`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_branch
  import ex_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic                ex_stall,
  input  logic                id_bubble,
  input  ex_op_e              id_op,
  input  logic [`EX_XLEN-1:0] id_pc,
  input  logic [`EX_XLEN-1:0] id_imm,
  input  logic                id_bp_taken,
  input  logic [`EX_XLEN-1:0] opA,
  input  logic [`EX_XLEN-1:0] opB,
  output logic                bu_flush,
  output logic [`EX_XLEN-1:0] bu_nxt_pc,
  output logic [`EX_XLEN-1:0] bu_r,
  output logic                bu_bubble
);

  // Fall-through distance, no compressed instructions
  localparam logic [`EX_XLEN-1:0] PC_STEP = `EX_XLEN'(4);

  logic is_br;
  logic taken;

  assign is_br = id_op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL};

  // Branch condition
  always_comb begin
    case (id_op)
      OP_BEQ:  taken = (opA == opB);
      OP_BNE:  taken = (opA != opB);
      OP_BLT:  taken = ($signed(opA) < $signed(opB));
      OP_BGE:  taken = ($signed(opA) >= $signed(opB));
      OP_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Flush on mispredict only
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bu_flush  <= 1'b0;
      bu_bubble <= 1'b1;
    end else if (!ex_stall) begin
      bu_flush  <= is_br && !id_bubble && (taken != id_bp_taken);
      bu_bubble <= !(is_br && !id_bubble);
    end
  end

  // Target or fall-through, plus link value
  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      bu_nxt_pc <= taken ? id_pc + id_imm : id_pc + PC_STEP;
      bu_r      <= id_pc + PC_STEP;
    end
  end

endmodule

//--- src/ex_consts.svh
// Execution stage constants
// Data width, program counter reset value and divider iteration count
// shared by every unit of the stage

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// Data and address width
`define EX_XLEN 32

// Value of ex_pc out of reset
`define EX_PC_INIT 32'h8000_0000

//////////////////////////////////////////////////
// Divider
//////////////////////////////////////////////////

// One quotient bit per iteration
`define EX_DIV_STEPS `EX_XLEN

`endif

//--- src/ex_div.sv
// Iterative divider
// Restoring division over operand magnitudes, one quotient bit per cycle,
// signs fixed once the iterations end. Holds the stage while busy

`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_div
  import ex_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic                ex_stall,
  input  logic                id_bubble,
  input  ex_op_e              id_op,
  input  logic [`EX_XLEN-1:0] opA,
  input  logic [`EX_XLEN-1:0] opB,
  output logic [`EX_XLEN-1:0] div_r,
  output logic                div_bubble,
  output logic                div_stall
);

  localparam int CNT_W = $clog2(`EX_DIV_STEPS);
  localparam int MSB   = `EX_XLEN - 1;

  div_state_e          state;
  logic [CNT_W-1:0]    cnt;
  // Working registers
  logic [`EX_XLEN-1:0] quo;
  logic [`EX_XLEN-1:0] rem;
  logic [`EX_XLEN-1:0] dvs;
  logic                neg_q;
  logic                neg_r;
  logic                is_rem;
  logic                dz;
  // Decode of the incoming op
  logic                is_div;
  logic                start;
  logic                is_signed;
  logic                a_neg;
  logic                b_neg;
  logic [`EX_XLEN-1:0] mag_a;
  logic [`EX_XLEN-1:0] mag_b;
  // One restoring step
  logic [`EX_XLEN:0]   rem_sh;
  logic [`EX_XLEN:0]   diff;
  // Sign-corrected results
  logic [`EX_XLEN-1:0] q_fix;
  logic [`EX_XLEN-1:0] r_fix;

  assign is_div    = id_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign start     = (state == DIV_IDLE) && !ex_stall && is_div && !id_bubble;
  assign is_signed = (id_op == OP_DIV) || (id_op == OP_REM);
  assign a_neg     = is_signed && opA[MSB];
  assign b_neg     = is_signed && opB[MSB];
  assign mag_a     = a_neg ? -opA : opA;
  assign mag_b     = b_neg ? -opB : opB;

  // Shift in next dividend bit, trial subtract
  assign rem_sh = {rem, quo[MSB]};
  assign diff   = rem_sh - {1'b0, dvs};

  // Divide by zero forces all ones, remainder keeps the dividend.
  // Min over -1 needs nothing: the magnitude quotient already wraps right
  assign q_fix = dz ? '1 : (neg_q ? -quo : quo);
  assign r_fix = neg_r ? -rem : rem;

  // Busy from the cycle after acceptance until the result is out
  assign div_stall = (state != DIV_IDLE);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= DIV_IDLE;
      cnt        <= '0;
      div_bubble <= 1'b1;
    end else begin
      case (state)
        DIV_IDLE: begin
          // Any accept retires the previous result
          if (!ex_stall) begin
            div_bubble <= 1'b1;
          end
          if (start) begin
            state <= DIV_RUN;
            cnt   <= CNT_W'(`EX_DIV_STEPS - 1);
          end
        end
        // Keeps going under wb_stall
        DIV_RUN: begin
          cnt <= cnt - 1'b1;
          if (cnt == '0) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          div_bubble <= 1'b0;
          state      <= DIV_IDLE;
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (start) begin
      quo    <= mag_a;
      rem    <= '0;
      dvs    <= mag_b;
      neg_q  <= a_neg ^ b_neg;
      neg_r  <= a_neg;
      is_rem <= (id_op == OP_REM) || (id_op == OP_REMU);
      dz     <= (opB == '0);
    end else if (state == DIV_RUN) begin
      // Restore when the trial went negative
      rem <= diff[`EX_XLEN] ? rem_sh[MSB:0] : diff[MSB:0];
      quo <= {quo[MSB-1:0], !diff[`EX_XLEN]};
    end else if (state == DIV_DONE) begin
      div_r <= is_rem ? r_fix : q_fix;
    end
  end

endmodule

//--- src/ex_lsu.sv
// Load-store unit
// Issues one data-memory access per LW/SW, holds the request steady
// and stalls the stage until dmem_ack

`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_lsu
  import ex_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic                ex_stall,
  input  logic                id_bubble,
  input  ex_op_e              id_op,
  input  logic [`EX_XLEN-1:0] id_imm,
  input  logic [`EX_XLEN-1:0] opA,
  input  logic [`EX_XLEN-1:0] opB,
  output logic [`EX_XLEN-1:0] lsu_r,
  output logic                lsu_bubble,
  output logic                lsu_stall,
  output logic [`EX_XLEN-1:0] dmem_adr,
  output logic [`EX_XLEN-1:0] dmem_d,
  output logic                dmem_req,
  output logic                dmem_we,
  input  logic                dmem_ack,
  input  logic [`EX_XLEN-1:0] dmem_q
);

  lsu_state_e state;
  logic       is_mem;
  logic       start;
  logic       done;

  assign is_mem = (id_op == OP_LW) || (id_op == OP_SW);
  assign start  = (state == LSU_IDLE) && !ex_stall && is_mem && !id_bubble;
  assign done   = (state == LSU_WAIT) && dmem_ack;

  // High in the same cycles as dmem_req
  assign lsu_stall = (state == LSU_WAIT);

  // Request FSM
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= LSU_IDLE;
      dmem_req   <= 1'b0;
      dmem_we    <= 1'b0;
      lsu_bubble <= 1'b1;
    end else if (start) begin
      state      <= LSU_WAIT;
      dmem_req   <= 1'b1;
      dmem_we    <= (id_op == OP_SW);
      lsu_bubble <= 1'b1;
    end else if (done) begin
      // Request drops the cycle after ack
      state      <= LSU_IDLE;
      dmem_req   <= 1'b0;
      dmem_we    <= 1'b0;
      lsu_bubble <= 1'b0;
    end else if ((state == LSU_IDLE) && !ex_stall) begin
      lsu_bubble <= 1'b1;
    end
  end

  // Address and store data frozen while waiting
  always_ff @(posedge clk) begin
    if (start) begin
      dmem_adr <= opA + id_imm;
      dmem_d   <= opB;
    end
    // Stores report zero
    if (done) begin
      lsu_r <= dmem_we ? '0 : dmem_q;
    end
  end

endmodule

//--- src/ex_pkg.sv
// Execution stage types
// Opcode handed over by decode, plus the FSM states
// of the divider and the load-store unit

package ex_pkg;

  // Decoded operation, one per instruction
  typedef enum logic [4:0] {
    OP_NOP,
    // Integer ALU
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    // Branch unit
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL,
    // Iterative divider
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    // Load-store unit
    OP_LW, OP_SW
  } ex_op_e;

  // Divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

  // Load-store FSM, waits on dmem_ack
  typedef enum logic {
    LSU_IDLE,
    LSU_WAIT
  } lsu_state_e;

endpackage

//--- src/ex_stage.sv
// Execution stage top level
// Operand bypass selection, pc and opcode registers, and the merge of
// stalls, bubbles and results from the ALU, branch, divider and LSU

`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  // Decode side
  input  logic                id_bubble,
  input  ex_op_e              id_op,
  input  logic [`EX_XLEN-1:0] id_pc,
  input  logic [`EX_XLEN-1:0] id_imm,
  input  logic                id_opB_imm,
  input  logic                id_bp_taken,
  input  logic                id_byp_ex_a,
  input  logic                id_byp_mem_a,
  input  logic                id_byp_wb_a,
  input  logic                id_byp_ex_b,
  input  logic                id_byp_mem_b,
  input  logic                id_byp_wb_b,
  // Register file
  input  logic [`EX_XLEN-1:0] rf_src1,
  input  logic [`EX_XLEN-1:0] rf_src2,
  // Later stages
  input  logic [`EX_XLEN-1:0] mem_r,
  input  logic [`EX_XLEN-1:0] wb_r,
  input  logic                wb_stall,
  // Stage outputs
  output logic                ex_stall,
  output logic                ex_bubble,
  output logic [`EX_XLEN-1:0] ex_pc,
  output ex_op_e              ex_op,
  output logic [`EX_XLEN-1:0] ex_r,
  output logic                bu_flush,
  output logic [`EX_XLEN-1:0] bu_nxt_pc,
  // Data memory
  output logic [`EX_XLEN-1:0] dmem_adr,
  output logic [`EX_XLEN-1:0] dmem_d,
  output logic                dmem_req,
  output logic                dmem_we,
  input  logic                dmem_ack,
  input  logic [`EX_XLEN-1:0] dmem_q
);

  logic [`EX_XLEN-1:0] opA;
  logic [`EX_XLEN-1:0] opB;
  // Unit results and bubbles
  logic [`EX_XLEN-1:0] alu_r;
  logic [`EX_XLEN-1:0] bu_r;
  logic [`EX_XLEN-1:0] div_r;
  logic [`EX_XLEN-1:0] lsu_r;
  logic                alu_bubble;
  logic                bu_bubble;
  logic                div_bubble;
  logic                lsu_bubble;
  logic                div_stall;
  logic                lsu_stall;

  //////////////////////////////////////////////////
  // Operand bypass
  //////////////////////////////////////////////////

  // Youngest producer wins
  always_comb begin
    if (id_byp_ex_a)       opA = ex_r;
    else if (id_byp_mem_a) opA = mem_r;
    else if (id_byp_wb_a)  opA = wb_r;
    else                   opA = rf_src1;
  end

  // Immediate only below the bypasses
  always_comb begin
    if (id_byp_ex_b)       opB = ex_r;
    else if (id_byp_mem_b) opB = mem_r;
    else if (id_byp_wb_b)  opB = wb_r;
    else if (id_opB_imm)   opB = id_imm;
    else                   opB = rf_src2;
  end

  // Pc and opcode follow the accepted instruction
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ex_pc <= `EX_PC_INIT;
      ex_op <= OP_NOP;
    end else if (!ex_stall) begin
      ex_pc <= id_pc;
      ex_op <= id_bubble ? OP_NOP : id_op;
    end
  end

  //////////////////////////////////////////////////
  // Execution units
  //////////////////////////////////////////////////

  ex_alu alu_i (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_op      (id_op),
    .opA        (opA),
    .opB        (opB),
    .alu_r      (alu_r),
    .alu_bubble (alu_bubble)
  );

  ex_branch bu_i (
    .clk         (clk),
    .rstn        (rstn),
    .ex_stall    (ex_stall),
    .id_bubble   (id_bubble),
    .id_op       (id_op),
    .id_pc       (id_pc),
    .id_imm      (id_imm),
    .id_bp_taken (id_bp_taken),
    .opA         (opA),
    .opB         (opB),
    .bu_flush    (bu_flush),
    .bu_nxt_pc   (bu_nxt_pc),
    .bu_r        (bu_r),
    .bu_bubble   (bu_bubble)
  );

  ex_div div_i (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_op      (id_op),
    .opA        (opA),
    .opB        (opB),
    .div_r      (div_r),
    .div_bubble (div_bubble),
    .div_stall  (div_stall)
  );

  ex_lsu lsu_i (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_op      (id_op),
    .id_imm     (id_imm),
    .opA        (opA),
    .opB        (opB),
    .lsu_r      (lsu_r),
    .lsu_bubble (lsu_bubble),
    .lsu_stall  (lsu_stall),
    .dmem_adr   (dmem_adr),
    .dmem_d     (dmem_d),
    .dmem_req   (dmem_req),
    .dmem_we    (dmem_we),
    .dmem_ack   (dmem_ack),
    .dmem_q     (dmem_q)
  );

  // Stage stall and bubble
  assign ex_stall  = wb_stall | lsu_stall | div_stall;
  assign ex_bubble = alu_bubble & bu_bubble & div_bubble & lsu_bubble;

  // Result from whichever unit holds a live result, ALU otherwise
  always_comb begin
    if (!lsu_bubble)      ex_r = lsu_r;
    else if (!div_bubble) ex_r = div_r;
    else if (!bu_bubble)  ex_r = bu_r;
    else                  ex_r = alu_r;
  end

endmodule

//--- verif/ex_ref_model.svh
// Reference model of the execution stage
// Operand selection, ALU, branch, divider and memory rules,
// plus the model's own copy of the last result and of data memory

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Last result shown on ex_r, valid only after a real instruction
logic [31:0] model_last_r;
logic        model_last_valid;
// Data memory as the model expects it
logic [31:0] model_mem [logic [31:0]];

// Untouched memory words, built from every address bit
function automatic logic [31:0] fill_word(input logic [31:0] adr);
  return {adr[15:0], ~adr[31:16]} ^ 32'h5A3C_96E1;
endfunction

function automatic logic [31:0] model_read(input logic [31:0] adr);
  if (model_mem.exists(adr)) begin
    return model_mem[adr];
  end
  return fill_word(adr);
endfunction

// Bypass priority: own result, then mem, then wb, then imm, then regfile
function automatic logic [31:0] pick_operand(input logic ex_f, input logic mem_f,
                                             input logic wb_f, input logic imm_f,
                                             input logic [31:0] last_r,
                                             input logic [31:0] mem_v,
                                             input logic [31:0] wb_v,
                                             input logic [31:0] imm_v,
                                             input logic [31:0] rf_v);
  if (ex_f) return last_r;
  if (mem_f) return mem_v;
  if (wb_f) return wb_v;
  if (imm_f) return imm_v;
  return rf_v;
endfunction

function automatic logic [31:0] alu_model(input ex_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  sa = a;
  sb = b;
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a + ~b + 32'd1;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << b[4:0];
    OP_SRL:  return a >> b[4:0];
    OP_SRA:  return 32'(sa >>> b[4:0]);
    OP_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
    OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
    default: return 32'd0;
  endcase
endfunction

function automatic logic branch_taken(input ex_op_e op, input logic [31:0] a,
                                      input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  sa = a;
  sb = b;
  case (op)
    OP_BEQ:  return a == b;
    OP_BNE:  return a != b;
    OP_BLT:  return sa < sb;
    OP_BGE:  return !(sa < sb);
    default: return 1'b1;
  endcase
endfunction

// RISC-V division rules, zero divisor and overflow handled first
function automatic logic [31:0] div_model(input ex_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic               ovf;
  sa  = a;
  sb  = b;
  ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
  case (op)
    OP_DIVU: return (b == 0) ? 32'hFFFF_FFFF : a / b;
    OP_REMU: return (b == 0) ? a : a % b;
    OP_DIV: begin
      if (b == 0) return 32'hFFFF_FFFF;
      if (ovf) return a;
      return 32'(sa / sb);
    end
    default: begin
      if (b == 0) return a;
      if (ovf) return 32'd0;
      return 32'(sa % sb);
    end
  endcase
endfunction

`endif

//--- verif/ex_stage_tb.sv
// Execution stage testbench
// Seeded random instruction stream with bypass selects and wb_stall,
// a data-memory responder and a reference model that predicts each result

`timescale 1ns/10ps
`include "ex_consts.svh"

module ex_stage_tb
  import ex_pkg::*;
();

  localparam int N_INSTR = 300;
  // Worst case per instruction is a division plus some slack
  localparam int CYCLE_LIMIT = N_INSTR * (`EX_DIV_STEPS + 8) + 20;

  logic        clk;
  logic        rstn;
  logic        id_bubble;
  ex_op_e      id_op;
  logic [31:0] id_pc;
  logic [31:0] id_imm;
  logic        id_opB_imm;
  logic        id_bp_taken;
  logic        id_byp_ex_a;
  logic        id_byp_mem_a;
  logic        id_byp_wb_a;
  logic        id_byp_ex_b;
  logic        id_byp_mem_b;
  logic        id_byp_wb_b;
  logic [31:0] rf_src1;
  logic [31:0] rf_src2;
  logic [31:0] mem_r;
  logic [31:0] wb_r;
  logic        wb_stall;
  logic        ex_stall;
  logic        ex_bubble;
  logic [31:0] ex_pc;
  ex_op_e      ex_op;
  logic [31:0] ex_r;
  logic        bu_flush;
  logic [31:0] bu_nxt_pc;
  logic [31:0] dmem_adr;
  logic [31:0] dmem_d;
  logic        dmem_req;
  logic        dmem_we;
  logic        dmem_ack;
  logic [31:0] dmem_q;

  `include "ex_ref_model.svh"

  // Expected results, in acceptance order
  logic [31:0] q_r [$];
  logic [31:0] q_pc [$];
  logic [31:0] q_nxt [$];
  logic        q_flush [$];
  logic        q_isbr [$];
  ex_op_e      q_op [$];
  // Expected memory request and responder state
  logic [31:0] exp_adr;
  logic [31:0] exp_d;
  logic        exp_we;
  logic        mem_pending;
  logic        req_seen;
  int          ack_wait;
  logic [31:0] resp_mem [logic [31:0]];
  // Previous cycle snapshot for the hold checks
  logic        prev_stall;
  logic        prev_bubble;
  logic [31:0] prev_pc;
  ex_op_e      prev_op;
  logic [31:0] prev_r;
  int          cycles;
  int          accepted;
  int          shown;
  int          issued;
  logic        have_instr;

  ex_stage ex_stage_i (.*);

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "run stopped at cycle %0d", cycles);
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (exp === act) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Runaway guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: stage did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  function automatic string op_group(input ex_op_e op);
    if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL}) return "branch";
    if (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) return "div";
    if (op inside {OP_LW, OP_SW}) return "lsu";
    return "alu";
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic draw_instr();
    logic [4:0] code;
    int         pick;
    code         = 5'($urandom_range(0, 21));
    id_op        = ex_op_e'(code);
    id_bubble    = ($urandom_range(0, 9) == 0);
    id_pc        = $urandom & 32'hFFFF_FFFC;
    id_imm       = $urandom;
    id_bp_taken  = 1'($urandom_range(0, 1));
    id_opB_imm   = 1'($urandom_range(0, 1));
    rf_src1      = $urandom;
    rf_src2      = $urandom;
    mem_r        = $urandom;
    wb_r         = $urandom;
    // Own-result bypass only when the model knows ex_r
    id_byp_ex_a  = ($urandom_range(0, 3) == 0) && model_last_valid;
    id_byp_mem_a = ($urandom_range(0, 3) == 0);
    id_byp_wb_a  = ($urandom_range(0, 3) == 0);
    id_byp_ex_b  = ($urandom_range(0, 3) == 0) && model_last_valid;
    id_byp_mem_b = ($urandom_range(0, 3) == 0);
    id_byp_wb_b  = ($urandom_range(0, 3) == 0);
    pick         = int'($urandom_range(0, 7));
    if (op_group(id_op) == "branch") begin
      id_imm = id_imm & 32'hFFFF_FFFE;
      // Equal operands from the regfile
      if (pick < 3) begin
        {id_byp_ex_a, id_byp_mem_a, id_byp_wb_a} = 3'b000;
        {id_byp_ex_b, id_byp_mem_b, id_byp_wb_b, id_opB_imm} = 4'b0000;
        rf_src2 = rf_src1;
      end
    end else if (op_group(id_op) == "div" && pick < 4) begin
      {id_byp_ex_b, id_byp_mem_b, id_byp_wb_b, id_opB_imm} = 4'b0000;
      if (pick < 2) begin
        rf_src2 = 32'd0;
      end else if (pick == 2) begin
        // Most negative over minus one
        {id_byp_ex_a, id_byp_mem_a, id_byp_wb_a} = 3'b000;
        rf_src1 = 32'h8000_0000;
        rf_src2 = 32'hFFFF_FFFF;
      end else begin
        rf_src2 = 32'($urandom_range(1, 100));
      end
    end else if (op_group(id_op) == "lsu") begin
      // Small address window so loads hit earlier stores
      {id_byp_ex_a, id_byp_mem_a, id_byp_wb_a} = 3'b000;
      rf_src1 = 32'h100 + 32'(4 * $urandom_range(0, 15));
      id_imm  = 32'(4 * $urandom_range(0, 3));
    end
  endtask

  // Model update for the instruction taken at the coming edge
  task automatic accept_instr();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        tk;
    logic        flush;
    logic [31:0] nxt;
    if (id_bubble || id_op == OP_NOP) begin
      model_last_valid = 1'b0;
    end else begin
      a = pick_operand(id_byp_ex_a, id_byp_mem_a, id_byp_wb_a, 1'b0,
                       model_last_r, mem_r, wb_r, id_imm, rf_src1);
      b = pick_operand(id_byp_ex_b, id_byp_mem_b, id_byp_wb_b, id_opB_imm,
                       model_last_r, mem_r, wb_r, id_imm, rf_src2);
      flush = 1'b0;
      nxt   = 32'd0;
      if (op_group(id_op) == "branch") begin
        tk    = branch_taken(id_op, a, b);
        flush = (tk != id_bp_taken);
        nxt   = tk ? id_pc + id_imm : id_pc + 32'd4;
        res   = id_pc + 32'd4;
      end else if (op_group(id_op) == "div") begin
        res = div_model(id_op, a, b);
      end else if (op_group(id_op) == "lsu") begin
        exp_adr     = a + id_imm;
        exp_d       = b;
        exp_we      = (id_op == OP_SW);
        mem_pending = 1'b1;
        if (exp_we) begin
          model_mem[exp_adr] = b;
          res = 32'd0;
        end else begin
          res = model_read(exp_adr);
        end
      end else begin
        res = alu_model(id_op, a, b);
      end
      q_r.push_back(res);
      q_pc.push_back(id_pc);
      q_nxt.push_back(nxt);
      q_flush.push_back(flush);
      q_isbr.push_back(op_group(id_op) == "branch");
      q_op.push_back(id_op);
      model_last_r     = res;
      model_last_valid = 1'b1;
      accepted++;
    end
  endtask

  //////////////////////////////////////////////////
  // Data-memory responder and checks
  //////////////////////////////////////////////////

  task automatic respond_memory();
    if (dmem_req) begin
      // Request only while a load or store is outstanding
      assert (mem_pending) else begin
        $display("dmem_req high with no load or store outstanding");
        abort_run();
      end
      if (!req_seen) begin
        req_seen = 1'b1;
        ack_wait = int'($urandom_range(0, 5));
      end
      // Request must match the model and stay steady
      compare_value("lsu dmem_adr", exp_adr, dmem_adr);
      compare_value("lsu dmem_d", exp_d, dmem_d);
      compare_value("lsu dmem_we", 32'(exp_we), 32'(dmem_we));
      if (ack_wait == 0) begin
        dmem_ack = 1'b1;
        if (dmem_we) begin
          resp_mem[dmem_adr] = dmem_d;
          dmem_q = 32'hDEAD_0000;
        end else begin
          dmem_q = resp_mem.exists(dmem_adr) ? resp_mem[dmem_adr] : fill_word(dmem_adr);
        end
        mem_pending = 1'b0;
      end else begin
        ack_wait--;
        dmem_ack = 1'b0;
      end
    end else begin
      dmem_ack = 1'b0;
      req_seen = 1'b0;
    end
  endtask

  task automatic check_result();
    string grp;
    assert (q_r.size() > 0) else begin
      $display("Result shown with no accepted instruction outstanding");
      abort_run();
    end
    grp = op_group(q_op[0]);
    compare_value({grp, " ex_r"}, q_r[0], ex_r);
    compare_value({grp, " ex_pc"}, q_pc[0], ex_pc);
    compare_value({grp, " ex_op"}, 32'(q_op[0]), 32'(ex_op));
    compare_value({grp, " bu_flush"}, 32'(q_flush[0]), 32'(bu_flush));
    if (q_isbr[0]) begin
      compare_value("branch bu_nxt_pc", q_nxt[0], bu_nxt_pc);
    end
    void'(q_r.pop_front());
    void'(q_pc.pop_front());
    void'(q_nxt.pop_front());
    void'(q_flush.pop_front());
    void'(q_isbr.pop_front());
    void'(q_op.pop_front());
    shown++;
  endtask

  // Registers hold across stalled edges
  task automatic check_hold();
    if (prev_stall) begin
      compare_value("hold ex_pc", prev_pc, ex_pc);
      compare_value("hold ex_op", 32'(prev_op), 32'(ex_op));
      if (!prev_bubble) begin
        compare_value("hold ex_r", prev_r, ex_r);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(4182));
    clk          = 1'b0;
    rstn         = 1'b0;
    id_bubble    = 1'b1;
    id_op        = OP_NOP;
    id_pc        = '0;
    id_imm       = '0;
    id_opB_imm   = 1'b0;
    id_bp_taken  = 1'b0;
    {id_byp_ex_a, id_byp_mem_a, id_byp_wb_a} = 3'b000;
    {id_byp_ex_b, id_byp_mem_b, id_byp_wb_b} = 3'b000;
    rf_src1      = '0;
    rf_src2      = '0;
    mem_r        = '0;
    wb_r         = '0;
    wb_stall     = 1'b0;
    dmem_ack     = 1'b0;
    dmem_q       = '0;
    model_last_r     = '0;
    model_last_valid = 1'b0;
    mem_pending  = 1'b0;
    req_seen     = 1'b0;
    ack_wait     = 0;
    prev_stall   = 1'b0;
    prev_bubble  = 1'b1;
    prev_pc      = '0;
    prev_op      = OP_NOP;
    prev_r       = '0;
    cycles       = 0;
    accepted     = 0;
    shown        = 0;
    issued       = 0;
    have_instr   = 1'b0;

    repeat (4) @(negedge clk);
    rstn = 1'b1;
    #1;
    // Reset values, before the first active edge
    compare_value("reset ex_pc", `EX_PC_INIT, ex_pc);
    compare_value("reset ex_bubble", 32'd1, 32'(ex_bubble));
    compare_value("reset bu_flush", 32'd0, 32'(bu_flush));
    compare_value("reset dmem_req", 32'd0, 32'(dmem_req));
    compare_value("reset ex_stall", 32'd0, 32'(ex_stall));

    while (issued < N_INSTR || have_instr || q_r.size() > 0) begin
      @(negedge clk);
      respond_memory();
      wb_stall = ($urandom_range(0, 9) == 0);
      if (!have_instr) begin
        if (issued < N_INSTR) begin
          draw_instr();
          issued++;
          have_instr = 1'b1;
        end else begin
          id_bubble = 1'b1;
        end
      end
      #1;
      check_hold();
      if (!ex_stall && !ex_bubble) begin
        check_result();
      end
      if (!ex_stall) begin
        accept_instr();
        have_instr = 1'b0;
      end
      prev_stall  = ex_stall;
      prev_bubble = ex_bubble;
      prev_pc     = ex_pc;
      prev_op     = ex_op;
      prev_r      = ex_r;
    end

    // Quiet cycles after the last result, a repeated result counts here
    repeat (4) begin
      @(negedge clk);
      respond_memory();
      wb_stall = 1'b0;
      #1;
      if (!ex_stall && !ex_bubble) begin
        shown++;
      end
    end

    // Nothing lost or repeated
    if (accepted == shown) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Accepted %0d instructions but saw %0d results", accepted, shown);
      abort_run();
    end
  end

endmodule
